/* hdl/bit_unstuffer.sv */
// bit_unstuffer: drops the stuffed zero after a run of ones and flags stuff errors
`default_nettype none

module bit_unstuffer (
    input  logic clk,
    input  logic rst_L,
    input  logic line_bit,
    input  logic line_valid,
    input  logic eop,
    input  logic eop_error,
    output logic data_bit,
    output logic data_valid,
    output logic stuff_error
);
    import usb_rx_pkg::*;

    // consecutive ones seen so far
    logic [2:0] run_cnt;

    always_ff @(posedge clk or negedge rst_L) begin
        if (!rst_L) begin
            run_cnt     <= '0;
            data_valid  <= 1'b0;
            stuff_error <= 1'b0;
        end else begin
            data_valid  <= 1'b0;
            stuff_error <= 1'b0;
            if (eop || eop_error) begin
                // packet over, next one starts with a fresh run
                run_cnt <= '0;
            end else if (line_valid) begin
                if (run_cnt == 3'(STUFF_RUN)) begin
                    // this bit is the stuffed one, swallow it
                    // a one here means the sender skipped the stuffing
                    stuff_error <= line_bit;
                    run_cnt     <= '0;
                end else begin
                    data_valid <= 1'b1;
                    run_cnt    <= line_bit ? run_cnt + 3'd1 : 3'd0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_valid) begin
            data_bit <= line_bit;
        end
    end

endmodule

`default_nettype wire

/* hdl/crc_checker.sv */
// crc_checker: serial crc5/crc16 shift register with residue compare
`default_nettype none

module crc_checker (
    input  logic clk,
    input  logic rst_L,
    input  logic data_bit,
    input  logic data_valid,
    input  logic crc_start,
    input  logic crc_en,
    input  logic crc16,
    output logic crc_ok
);
    import usb_rx_pkg::*;

    // crc5 only uses bits 4:0
    logic [15:0] crc_reg;
    logic        fb5;
    logic        fb16;

    // feedback is the msb xored with the incoming bit
    assign fb5  = crc_reg[4] ^ data_bit;
    assign fb16 = crc_reg[15] ^ data_bit;

    always_ff @(posedge clk or negedge rst_L) begin
        if (!rst_L) begin
            crc_reg <= '1;
        end else if (crc_start) begin
            // preset to all ones before the field
            crc_reg <= '1;
        end else if (crc_en && data_valid) begin
            if (crc16) begin
                crc_reg <= {crc_reg[14:0], 1'b0} ^ (fb16 ? CRC16_POLY : 16'h0000);
            end else begin
                crc_reg[4:0] <= {crc_reg[3:0], 1'b0} ^ (fb5 ? CRC5_POLY : 5'h00);
            end
        end
    end

    // field and crc shifted through leave the fixed residue
    always_comb begin
        if (crc16) begin
            crc_ok = (crc_reg == CRC16_RESIDUE);
        end else begin
            crc_ok = (crc_reg[4:0] == CRC5_RESIDUE);
        end
    end

endmodule

`default_nettype wire

/* hdl/nrzi_decoder.sv */
// nrzi_decoder: line sampler with nrzi decode, eop detection and the rx_active flag
`default_nettype none

module nrzi_decoder (
    input  logic                    clk,
    input  logic                    rst_L,
    input  logic                    decode,
    input  usb_rx_pkg::line_state_t port,
    output logic                    line_bit,
    output logic                    line_valid,
    output logic                    eop,
    output logic                    eop_error,
    output logic                    rx_active
);
    import usb_rx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_EOP
    } state_t;

    state_t      state;
    // last j/k sample, the reference for the next transition
    line_state_t prev;
    // second se0 of the eop already seen
    logic        se0_seen;

    always_ff @(posedge clk or negedge rst_L) begin
        if (!rst_L) begin
            state      <= ST_IDLE;
            prev       <= LINE_J;
            se0_seen   <= 1'b0;
            line_valid <= 1'b0;
            eop        <= 1'b0;
            eop_error  <= 1'b0;
            rx_active  <= 1'b0;
        end else begin
            // strobes are single cycle
            line_valid <= 1'b0;
            eop        <= 1'b0;
            eop_error  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // line idles in j, so the first k decodes as a zero
                    if (decode) begin
                        state     <= ST_DATA;
                        prev      <= LINE_J;
                        rx_active <= 1'b1;
                    end
                end
                ST_DATA: begin
                    case (port)
                        LINE_J, LINE_K: begin
                            line_valid <= 1'b1;
                            prev       <= port;
                        end
                        LINE_SE0: begin
                            state    <= ST_EOP;
                            se0_seen <= 1'b0;
                        end
                        default: begin
                            // se1 never belongs in a packet
                            eop_error <= 1'b1;
                            rx_active <= 1'b0;
                            state     <= ST_IDLE;
                        end
                    endcase
                end
                ST_EOP: begin
                    if (!se0_seen && port == LINE_SE0) begin
                        se0_seen <= 1'b1;
                    end else begin
                        // se0 se0 j is the only good ending
                        eop       <= se0_seen && port == LINE_J;
                        eop_error <= !(se0_seen && port == LINE_J);
                        se0_seen  <= 1'b0;
                        rx_active <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // no transition means a one
    always_ff @(posedge clk) begin
        if (state == ST_DATA) begin
            line_bit <= (port == prev);
        end
    end

endmodule

`default_nettype wire

/* hdl/packet_assembler.sv */
// packet_assembler: sync hunt, pid decode and check, field collection, crc control, packet status
`default_nettype none

module packet_assembler (
    input  logic                             clk,
    input  logic                             rst_L,
    input  logic                             data_bit,
    input  logic                             data_valid,
    input  logic                             eop,
    input  logic                             eop_error,
    input  logic                             stuff_error,
    input  logic                             crc_ok,
    output logic                             crc_start,
    output logic                             crc_en,
    output logic                             crc16,
    output logic                             done,
    output logic                             error,
    output usb_rx_pkg::pid_t                 pkt_pid,
    output logic [usb_rx_pkg::DATA_BITS-1:0] pkt_data
);
    import usb_rx_pkg::*;

    typedef enum logic [1:0] {
        ST_SYNC,
        ST_PID,
        ST_FIELD,
        ST_WAIT_EOP
    } state_t;

    state_t                           state;
    logic [$clog2(SYNC_ZEROS+1)-1:0]  zero_cnt;
    // pid bits in ST_PID, field plus crc bits afterwards
    logic [BIT_CNT_W-1:0]             bit_cnt;
    logic [BIT_CNT_W-1:0]             exp_len;
    logic [BIT_CNT_W-1:0]             data_len;
    // first seven pid bits, the eighth is taken straight from data_bit
    logic [PID_BITS-2:0]              pid_sr;
    logic                             has_crc;
    // sticky fault for the current packet
    logic                             fault;

    logic [PID_BITS-1:0]              pid_full;
    logic                             pid_known;
    logic                             pid_bad;
    logic                             nxt_crc16;
    logic [BIT_CNT_W-1:0]             nxt_data_len;
    logic [BIT_CNT_W-1:0]             nxt_crc_len;

    assign pid_full = {data_bit, pid_sr};
    assign crc_en   = (state == ST_FIELD);

    // ************************************************************
    // pid table
    // ************************************************************
    always_comb begin
        pid_known    = 1'b0;
        nxt_crc16    = 1'b0;
        nxt_data_len = '0;
        nxt_crc_len  = '0;
        case (pid_full[3:0])
            PID_OUT, PID_IN: begin
                pid_known    = 1'b1;
                nxt_data_len = BIT_CNT_W'(TOKEN_BITS);
                nxt_crc_len  = BIT_CNT_W'(CRC5_BITS);
            end
            PID_DATA0: begin
                pid_known    = 1'b1;
                nxt_crc16    = 1'b1;
                nxt_data_len = BIT_CNT_W'(DATA_BITS);
                nxt_crc_len  = BIT_CNT_W'(CRC16_BITS);
            end
            PID_ACK, PID_NAK: begin
                // handshakes carry no field
                pid_known = 1'b1;
            end
            default: pid_known = 1'b0;
        endcase
        // check nibble must be the complement of the type nibble
        pid_bad = (pid_full[7:4] != ~pid_full[3:0]) || !pid_known;
    end

    // ************************************************************
    // packet fsm
    // ************************************************************
    always_ff @(posedge clk or negedge rst_L) begin
        if (!rst_L) begin
            state     <= ST_SYNC;
            zero_cnt  <= '0;
            bit_cnt   <= '0;
            exp_len   <= '0;
            data_len  <= '0;
            pid_sr    <= '0;
            has_crc   <= 1'b0;
            fault     <= 1'b0;
            crc_start <= 1'b0;
            crc16     <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
            pkt_pid   <= pid_t'(4'h0);
            pkt_data  <= '0;
        end else begin
            done      <= 1'b0;
            crc_start <= 1'b0;
            if (eop || eop_error) begin
                // report the packet, whatever state it stopped in
                done    <= 1'b1;
                pkt_pid <= pid_t'(pid_sr[3:0]);
                error   <= fault || stuff_error || eop_error || (state == ST_SYNC) ||
                           (bit_cnt != exp_len) || (has_crc && !crc_ok);
                state    <= ST_SYNC;
                zero_cnt <= '0;
            end else if (data_valid) begin
                case (state)
                    ST_SYNC: begin
                        if (!data_bit) begin
                            if (zero_cnt != SYNC_ZEROS) begin
                                zero_cnt <= zero_cnt + 1'b1;
                            end
                        end else if (zero_cnt == SYNC_ZEROS) begin
                            // sync complete, start a new packet
                            state     <= ST_PID;
                            bit_cnt   <= '0;
                            fault     <= 1'b0;
                            pkt_data  <= '0;
                            crc_start <= 1'b1;
                        end else begin
                            zero_cnt <= '0;
                        end
                    end
                    ST_PID: begin
                        if (bit_cnt == BIT_CNT_W'(PID_BITS - 1)) begin
                            // last pid bit, pick the field layout
                            bit_cnt  <= '0;
                            data_len <= nxt_data_len;
                            exp_len  <= nxt_data_len + nxt_crc_len;
                            has_crc  <= (nxt_crc_len != '0);
                            crc16    <= nxt_crc16;
                            if (pid_bad) begin
                                fault <= 1'b1;
                            end
                            state <= (nxt_crc_len != '0) ? ST_FIELD : ST_WAIT_EOP;
                        end else begin
                            pid_sr[bit_cnt[2:0]] <= data_bit;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    ST_FIELD: begin
                        // lsb first, crc bits only go to the checker
                        if (bit_cnt < data_len) begin
                            pkt_data[bit_cnt[$clog2(DATA_BITS)-1:0]] <= data_bit;
                        end
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == exp_len - 1'b1) begin
                            state <= ST_WAIT_EOP;
                        end
                    end
                    ST_WAIT_EOP: begin
                        // extra bits only show up in the length check
                        if (bit_cnt != '1) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: state <= ST_SYNC;
                endcase
            end
            // stuff errors count once a packet has started
            if (stuff_error && state != ST_SYNC) begin
                fault <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/usb_rx_pkg.sv */
// usb receive package: line states, pid codes, field lengths, crc polynomials and residues
`default_nettype none

package usb_rx_pkg;

    // ************************************************************
    // line and pid encodings
    // ************************************************************

    // line states as seen on the d+/d- pair, 2'b11 (se1) is illegal
    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_K   = 2'b01,
        LINE_J   = 2'b10
    } line_state_t;

    // low nibble of the pid byte, the high nibble is its complement
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_DATA0 = 4'b0011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010
    } pid_t;

    // full pid byte including the check nibble
    localparam int PID_BITS = 8;

    // ************************************************************
    // framing and field lengths
    // ************************************************************

    // sync is seven zeros then a one
    localparam int SYNC_ZEROS = 7;

    // a zero is stuffed after this many ones in a row
    localparam int STUFF_RUN = 6;

    // addr + endp for tokens, fixed 8-byte payload for data0
    localparam int TOKEN_BITS = 11;
    localparam int DATA_BITS  = 64;

    localparam int CRC5_BITS  = 5;
    localparam int CRC16_BITS = 16;

    // bit counter covers the longest field plus its crc
    localparam int BIT_CNT_W = 7;

    // ************************************************************
    // crc constants
    // ************************************************************

    // x^5 + x^2 + 1
    localparam logic [4:0] CRC5_POLY = 5'h05;
    // x^16 + x^15 + x^2 + 1
    localparam logic [15:0] CRC16_POLY = 16'h8005;

    // register contents after a good field plus its inverted crc
    localparam logic [4:0]  CRC5_RESIDUE  = 5'h0C;
    localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

endpackage

`default_nettype wire

/* hdl/usb_rx_top.sv */
// usb_rx_top: full-speed receive chain of nrzi decoder, unstuffer, crc checker and assembler
`default_nettype none

module usb_rx_top (
    input  logic                             clk,
    input  logic                             rst_L,
    input  logic                             decode,
    input  usb_rx_pkg::line_state_t          port,
    output logic                             rx_active,
    output usb_rx_pkg::pid_t                 pkt_pid,
    output logic [usb_rx_pkg::DATA_BITS-1:0] pkt_data,
    output logic                             done,
    output logic                             error
);

    // decoder to unstuffer
    logic line_bit;
    logic line_valid;
    // end of packet status, also used by the assembler
    logic eop;
    logic eop_error;
    // unstuffed stream
    logic data_bit;
    logic data_valid;
    logic stuff_error;
    // crc control and result
    logic crc_start;
    logic crc_en;
    logic crc16;
    logic crc_ok;

    nrzi_decoder nrzi0 (
        .clk        (clk),
        .rst_L      (rst_L),
        .decode     (decode),
        .port       (port),
        .line_bit   (line_bit),
        .line_valid (line_valid),
        .eop        (eop),
        .eop_error  (eop_error),
        .rx_active  (rx_active)
    );

    bit_unstuffer unstuff0 (
        .clk         (clk),
        .rst_L       (rst_L),
        .line_bit    (line_bit),
        .line_valid  (line_valid),
        .eop         (eop),
        .eop_error   (eop_error),
        .data_bit    (data_bit),
        .data_valid  (data_valid),
        .stuff_error (stuff_error)
    );

    crc_checker crc0 (
        .clk        (clk),
        .rst_L      (rst_L),
        .data_bit   (data_bit),
        .data_valid (data_valid),
        .crc_start  (crc_start),
        .crc_en     (crc_en),
        .crc16      (crc16),
        .crc_ok     (crc_ok)
    );

    packet_assembler pack0 (
        .clk         (clk),
        .rst_L       (rst_L),
        .data_bit    (data_bit),
        .data_valid  (data_valid),
        .eop         (eop),
        .eop_error   (eop_error),
        .stuff_error (stuff_error),
        .crc_ok      (crc_ok),
        .crc_start   (crc_start),
        .crc_en      (crc_en),
        .crc16       (crc16),
        .done        (done),
        .error       (error),
        .pkt_pid     (pkt_pid),
        .pkt_data    (pkt_data)
    );

endmodule

`default_nettype wire

/* project.f */
+incdir+verification
hdl/usb_rx_pkg.sv
hdl/nrzi_decoder.sv
hdl/bit_unstuffer.sv
hdl/crc_checker.sv
hdl/packet_assembler.sv
hdl/usb_rx_top.sv
verification/usb_rx_tb.sv

/* verification/usb_line_model.svh */
// line model: lfsr, crc reference, sync and pid framing, bit stuffing, nrzi encoding, expected packet
`ifndef USB_LINE_MODEL_SVH
`define USB_LINE_MODEL_SVH

// bits of one packet in send order, bit 0 goes out first
typedef struct packed {
    int           len;
    logic [159:0] bits;
} stream_t;

typedef struct packed {
    logic [3:0]  pid;
    logic [63:0] data;
    logic        err;
} expect_t;

// 16-bit galois lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
endfunction

// one lfsr step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[i] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// usb crc over a field sent lsb first, preset to all ones
function automatic logic [15:0] crc_ref(input logic [63:0] field, input int n, input int width);
    logic [15:0] r;
    logic [15:0] poly;
    logic        fb;
    r    = 16'hFFFF;
    // x^16+x^15+x^2+1 or x^5+x^2+1
    poly = (width == 16) ? 16'h8005 : 16'h0005;
    for (int i = 0; i < n; i++) begin
        fb = r[width-1] ^ field[i];
        r  = {r[14:0], 1'b0} ^ (fb ? poly : 16'h0000);
    end
    return (width == 16) ? r : (r & 16'h001F);
endfunction

// sync, pid byte, field and inverted crc before stuffing
function automatic stream_t build_raw(input logic [7:0] pid_byte, input logic [63:0] field,
                                      input int field_len, input int crc_width,
                                      input logic [15:0] crc_flip);
    stream_t      s;
    logic [159:0] b;
    logic [15:0]  crc;
    int           n;
    b = '0;
    n = 0;
    // seven zeros then a one
    for (int i = 0; i < 8; i++) begin
        b[n] = (i == 7);
        n++;
    end
    for (int i = 0; i < 8; i++) begin
        b[n] = pid_byte[i];
        n++;
    end
    for (int i = 0; i < field_len; i++) begin
        b[n] = field[i];
        n++;
    end
    if (crc_width > 0) begin
        crc = ~crc_ref(field, field_len, crc_width) ^ crc_flip;
        // crc goes out msb first
        for (int i = crc_width - 1; i >= 0; i--) begin
            b[n] = crc[i];
            n++;
        end
    end
    s.len  = n;
    s.bits = b;
    return s;
endfunction

// zero after every six ones, optionally leave out the first one
function automatic stream_t stuff_bits(input stream_t raw, input bit drop_first);
    stream_t      s;
    logic [159:0] b;
    int           n;
    int           run;
    bit           dropped;
    b       = '0;
    n       = 0;
    run     = 0;
    dropped = 1'b0;
    for (int i = 0; i < raw.len; i++) begin
        b[n] = raw.bits[i];
        n++;
        run = raw.bits[i] ? run + 1 : 0;
        if (run == 6) begin
            if (drop_first && !dropped) begin
                dropped = 1'b1;
            end else begin
                b[n] = 1'b0;
                n++;
            end
            run = 0;
        end
    end
    s.len  = n;
    s.bits = b;
    return s;
endfunction

// a zero toggles the line, a one keeps it
function automatic line_state_t nrzi_next(input line_state_t prev, input logic b);
    if (b) begin
        return prev;
    end else if (prev == LINE_J) begin
        return LINE_K;
    end else begin
        return LINE_J;
    end
endfunction

function automatic expect_t expect_packet(input logic [7:0] pid_byte, input logic [63:0] field,
                                          input int field_len, input logic [15:0] crc_flip,
                                          input bit drop_stuff, input bit bad_eop);
    expect_t e;
    logic    known;
    // out, in, data0, ack, nak
    case (pid_byte[3:0])
        4'b0001, 4'b1001, 4'b0011, 4'b0010, 4'b1010: known = 1'b1;
        default: known = 1'b0;
    endcase
    e.pid  = pid_byte[3:0];
    e.data = (known && field_len > 0) ? field : 64'h0;
    e.err  = !known || (pid_byte[7:4] != ~pid_byte[3:0]) || (crc_flip != 16'h0000) ||
             drop_stuff || bad_eop;
    return e;
endfunction

`endif

/* verification/usb_rx_tb.sv */
// testbench for usb_rx_top with clock, reset, packet stimulus, comparison process and final report
`default_nettype none

module usb_rx_tb;
    import usb_rx_pkg::*;

    localparam int NUM_PKTS     = 12;
    localparam int DONE_TIMEOUT = 400;
    localparam int IDLE_TIMEOUT = 20;

    logic                 clk;
    logic                 rst_L;
    logic                 decode;
    line_state_t          port;
    logic                 rx_active;
    pid_t                 pkt_pid;
    logic [DATA_BITS-1:0] pkt_data;
    logic                 done;
    logic                 error;

    logic [15:0] lfsr_state;
    int          mismatches = 0;
    int          timeouts   = 0;
    int          n_sent     = 0;

    `include "usb_line_model.svh"

    // expected result of each packet as the stimulus sent it
    expect_t exp_mem [0:NUM_PKTS-1];

    usb_rx_top dut0 (
        .clk       (clk),
        .rst_L     (rst_L),
        .decode    (decode),
        .port      (port),
        .rx_active (rx_active),
        .pkt_pid   (pkt_pid),
        .pkt_data  (pkt_data),
        .done      (done),
        .error     (error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic send_packet(input logic [7:0] pid_byte, input logic [63:0] field,
                               input int field_len, input int crc_width,
                               input logic [15:0] crc_flip, input bit drop_stuff,
                               input bit bad_eop);
        stream_t     line;
        line_state_t lvl;
        int          cyc;
        exp_mem[n_sent] = expect_packet(pid_byte, field, field_len, crc_flip, drop_stuff, bad_eop);
        n_sent++;
        line = stuff_bits(build_raw(pid_byte, field, field_len, crc_width, crc_flip), drop_stuff);
        // arm the receiver with the line idle in j
        @(posedge clk);
        decode <= 1'b1;
        port   <= LINE_J;
        @(posedge clk);
        decode <= 1'b0;
        lvl    = LINE_J;
        for (int i = 0; i < line.len; i++) begin
            lvl = nrzi_next(lvl, line.bits[i]);
            port <= lvl;
            @(posedge clk);
        end
        // receiver stays active up to the last packet bit
        assert (rx_active === 1'b1) else begin
            $display("[FAIL] %0t packet %0d rx_active low during the packet", $time,
                     n_sent - 1);
            mismatches++;
        end
        // eop is se0 se0 j and the broken one puts k in place of the second se0
        port <= LINE_SE0;
        @(posedge clk);
        port <= bad_eop ? LINE_K : LINE_SE0;
        @(posedge clk);
        port <= LINE_J;
        cyc = 0;
        @(posedge clk);
        while (rx_active && cyc < IDLE_TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (rx_active) begin
            $display("rx_active did not drop after packet %0d", n_sent - 1);
            timeouts++;
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin : stimulus
        rst_L      = 1'b0;
        decode     = 1'b0;
        port       = LINE_J;
        lfsr_state = 16'd4;
        repeat (8) @(posedge clk);
        rst_L <= 1'b1;
        repeat (4) @(posedge clk);
        // good tokens, data and handshakes
        send_packet(8'hE1, rand_bits(TOKEN_BITS), TOKEN_BITS, 5, 16'h0, 1'b0, 1'b0);
        send_packet(8'h69, rand_bits(TOKEN_BITS), TOKEN_BITS, 5, 16'h0, 1'b0, 1'b0);
        send_packet(8'hC3, rand_bits(DATA_BITS), DATA_BITS, 16, 16'h0, 1'b0, 1'b0);
        send_packet(8'hC3, {64{1'b1}}, DATA_BITS, 16, 16'h0, 1'b0, 1'b0);
        send_packet(8'hD2, 64'h0, 0, 0, 16'h0, 1'b0, 1'b0);
        send_packet(8'h5A, 64'h0, 0, 0, 16'h0, 1'b0, 1'b0);
        // faulty packets
        send_packet(8'hE1, rand_bits(TOKEN_BITS), TOKEN_BITS, 5, 16'h0004, 1'b0, 1'b0);
        send_packet(8'h79, rand_bits(TOKEN_BITS), TOKEN_BITS, 5, 16'h0, 1'b0, 1'b0);
        send_packet(8'hA5, 64'h0, 0, 0, 16'h0, 1'b0, 1'b0);
        send_packet(8'hC3, {64{1'b1}}, DATA_BITS, 16, 16'h0, 1'b1, 1'b0);
        send_packet(8'hD2, 64'h0, 0, 0, 16'h0, 1'b0, 1'b1);
        // receiver must recover after the broken eop
        send_packet(8'hE1, rand_bits(TOKEN_BITS), TOKEN_BITS, 5, 16'h0, 1'b0, 1'b0);
    end

    // ************************************************************
    // comparison
    // ************************************************************
    task automatic check_packet(input int k);
        expect_t e;
        e = exp_mem[k];
        assert (pkt_pid === e.pid) else begin
            $display("[FAIL] %0t packet %0d pkt_pid %h expected %h", $time, k, pkt_pid, e.pid);
            mismatches++;
        end
        assert (error === e.err) else begin
            $display("[FAIL] %0t packet %0d error %b expected %b", $time, k, error, e.err);
            mismatches++;
        end
        // payload only means something for a clean packet
        if (!e.err) begin
            assert (pkt_data === e.data) else begin
                $display("[FAIL] %0t packet %0d pkt_data %h expected %h", $time, k, pkt_data,
                         e.data);
                mismatches++;
            end
        end
    endtask

    initial begin : compare
        int cyc;
        for (int k = 0; k < NUM_PKTS && timeouts == 0; k++) begin
            cyc = 0;
            @(posedge clk);
            while (done !== 1'b1 && cyc < DONE_TIMEOUT) begin
                @(posedge clk);
                cyc++;
            end
            if (done !== 1'b1) begin
                $display("no done seen for packet %0d", k);
                timeouts++;
            end else begin
                check_packet(k);
            end
        end
        $display("errors: %0d wrong values, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
